// ==== cpuCfg.svh ====
// Configuration macros for the pipelined RV32I subset core.
// Included by every RTL file and by the testbench.
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and register file size
`define WORD_WIDTH 32
`define NUM_REGS   32

// Major opcodes
`define OPCODE_COMPUTE 7'b0110011
`define OPCODE_IMM     7'b0010011
`define OPCODE_LOAD    7'b0000011
`define OPCODE_STORE   7'b0100011
`define OPCODE_BRANCH  7'b1100011
`define OPCODE_JUMP    7'b1101111
`define OPCODE_UPPER   7'b0110111

// funct7 values, add/sub and logical/arithmetic shift select
`define AUX_FUNC_BASE 7'b0000000
`define AUX_FUNC_ALT  7'b0100000

// Branch funct3 codes
`define FUNC_BEQ  3'b000
`define FUNC_BNE  3'b001
`define FUNC_BLT  3'b100
`define FUNC_BGE  3'b101
`define FUNC_BLTU 3'b110
`define FUNC_BGEU 3'b111

// ALU funct3 codes
`define FUNC_ADD  3'b000
`define FUNC_SLL  3'b001
`define FUNC_SLT  3'b010
`define FUNC_SLTU 3'b011
`define FUNC_XOR  3'b100
`define FUNC_SR   3'b101
`define FUNC_OR   3'b110

// addi x0, x0, 0
`define NOP_WORD 32'h00000013

`endif

// ==== cpuPkg.sv ====
// Shared types for the pipelined core: stage payloads and the data port.
// Imported by wildcard in each module header.
`include "cpuCfg.svh"

package cpuPkg;

   typedef logic [`WORD_WIDTH-1:0] word_t;
   typedef logic [$clog2(`NUM_REGS)-1:0] regIdx_t;

   typedef struct packed {
      logic  valid;
      word_t pc;
      word_t instr;
   } fetchOut_t;

   typedef struct packed {
      logic       valid;
      logic [6:0] opcode;
      logic [2:0] funct3;
      logic [6:0] funct7;
      regIdx_t    rs1;
      regIdx_t    rs2;
      regIdx_t    rd;
      word_t      pc;
      word_t      rs1Val;
      word_t      rs2Val;
      word_t      imm;
   } decodeOut_t;

   // Result holds the data address for loads and stores
   typedef struct packed {
      logic       valid;
      logic [6:0] opcode;
      regIdx_t    rd;
      logic       regWrite;
      word_t      result;
      word_t      storeData;
      logic       isLoad;
      logic       isStore;
      logic       known;
   } execOut_t;

   typedef struct packed {
      logic    we;
      regIdx_t rd;
      word_t   value;
   } wbOut_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  writeStrobe;
      logic  readStrobe;
   } dataReq_t;

endpackage

// ==== fetchStage.sv ====
// Instruction fetch. Holds the PC, presents it to the instruction memory
// and latches the returned word for decode.
`include "cpuCfg.svh"

module fetchStage import cpuPkg::*; (
   input  logic      clk,
   input  logic      reset,
   input  logic      halt,
   input  logic      stall,
   input  logic      redirect,
   input  word_t     redirectPc,
   output word_t     fetchAddr,
   input  word_t     fetchWord,
   output fetchOut_t fetchOut
);

   word_t pc;

   assign fetchAddr = pc;

   always_ff @(posedge clk) begin
      if (reset) begin
         pc             <= '0;
         fetchOut.valid <= 1'b0;
         fetchOut.pc    <= '0;
         fetchOut.instr <= `NOP_WORD;
      end else if (!halt) begin
         if (redirect) begin
            // Squash the wrong-path fetch
            pc             <= redirectPc;
            fetchOut.valid <= 1'b0;
            fetchOut.instr <= `NOP_WORD;
         end else if (!stall) begin
            pc             <= pc + `WORD_WIDTH'd4;
            fetchOut.valid <= 1'b1;
            fetchOut.pc    <= pc;
            fetchOut.instr <= fetchWord;
         end
      end
   end

endmodule

// ==== decodeStage.sv ====
// Instruction decode. Reads the register file, builds the immediate,
// detects load-use hazards and latches the decoded instruction for execute.
// The register file is written from the write-back payload.
`include "cpuCfg.svh"

module decodeStage import cpuPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       halt,
   input  fetchOut_t  fetchOut,
   input  logic       redirect,
   input  wbOut_t     wb,
   input  regIdx_t    execLoadDst,
   input  logic       execIsLoad,
   output logic       stall,
   output decodeOut_t decodeOut
);

   word_t      regs [`NUM_REGS];
   word_t      instr;
   logic [6:0] opcode;
   regIdx_t    rs1;
   regIdx_t    rs2;
   word_t      imm;
   logic       usesRs1;
   logic       usesRs2;

   assign instr  = fetchOut.instr;
   assign opcode = instr[6:0];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];

   // x0 reads zero, a same-cycle write is bypassed
   function automatic word_t readReg(regIdx_t idx);
      word_t val;
      if (idx == '0) begin
         val = '0;
      end else if (wb.we && wb.rd == idx) begin
         val = wb.value;
      end else begin
         val = regs[idx];
      end
      return val;
   endfunction

   always_ff @(posedge clk) begin
      if (wb.we) begin
         regs[wb.rd] <= wb.value;
      end
   end

   always_comb begin
      case (opcode)
         `OPCODE_STORE:  imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
         `OPCODE_BRANCH: imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
         `OPCODE_JUMP:   imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
         `OPCODE_UPPER:  imm = {instr[31:12], 12'b0};
         default:        imm = {{20{instr[31]}}, instr[31:20]};
      endcase
   end

   // Which source fields are real operands
   assign usesRs1 = (opcode == `OPCODE_COMPUTE) || (opcode == `OPCODE_IMM) ||
                    (opcode == `OPCODE_LOAD) || (opcode == `OPCODE_STORE) ||
                    (opcode == `OPCODE_BRANCH);
   assign usesRs2 = (opcode == `OPCODE_COMPUTE) || (opcode == `OPCODE_STORE) ||
                    (opcode == `OPCODE_BRANCH);

   assign stall = fetchOut.valid && execIsLoad && (execLoadDst != '0) &&
                  ((usesRs1 && rs1 == execLoadDst) || (usesRs2 && rs2 == execLoadDst));

   always_ff @(posedge clk) begin
      if (reset) begin
         decodeOut        <= '0;
         decodeOut.opcode <= `OPCODE_IMM;
         decodeOut.funct7 <= `AUX_FUNC_BASE;
      end else if (!halt) begin
         if (redirect || stall) begin
            // Bubble into execute
            decodeOut        <= '0;
            decodeOut.opcode <= `OPCODE_IMM;
            decodeOut.funct7 <= `AUX_FUNC_BASE;
         end else begin
            decodeOut.valid  <= fetchOut.valid;
            decodeOut.opcode <= opcode;
            decodeOut.funct3 <= instr[14:12];
            decodeOut.funct7 <= instr[31:25];
            decodeOut.rs1    <= rs1;
            decodeOut.rs2    <= rs2;
            decodeOut.rd     <= instr[11:7];
            decodeOut.pc     <= fetchOut.pc;
            decodeOut.rs1Val <= readReg(rs1);
            decodeOut.rs2Val <= readReg(rs2);
            decodeOut.imm    <= imm;
         end
      end
   end

endmodule

// ==== executeStage.sv ====
// Execute. Forwards operands from the memory and write-back stages, runs
// the ALU, resolves branches and JAL, and latches the result for memory.
`include "cpuCfg.svh"

module executeStage import cpuPkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  logic       halt,
   input  decodeOut_t decodeOut,
   input  execOut_t   memFwd,
   input  wbOut_t     wbFwd,
   output logic       redirect,
   output word_t      redirectPc,
   output execOut_t   execOut
);

   word_t opA;
   word_t opB;
   word_t aluB;
   word_t aluResult;
   word_t result;
   logic  isCompute;
   logic  isLoad;
   logic  isStore;
   logic  isBranch;
   logic  isJump;
   logic  isUpper;
   logic  known;
   logic  writesRd;
   logic  branchCond;

   // Memory stage wins over write-back, loads in memory are not ready yet
   function automatic word_t forward(regIdx_t idx, word_t regVal);
      word_t val;
      val = regVal;
      if (idx != '0 && wbFwd.we && wbFwd.rd == idx) begin
         val = wbFwd.value;
      end
      if (idx != '0 && memFwd.regWrite && !memFwd.isLoad && memFwd.rd == idx) begin
         val = memFwd.result;
      end
      return val;
   endfunction

   assign opA = forward(decodeOut.rs1, decodeOut.rs1Val);
   assign opB = forward(decodeOut.rs2, decodeOut.rs2Val);

   assign isCompute = decodeOut.opcode == `OPCODE_COMPUTE;
   assign isLoad    = decodeOut.opcode == `OPCODE_LOAD;
   assign isStore   = decodeOut.opcode == `OPCODE_STORE;
   assign isBranch  = decodeOut.opcode == `OPCODE_BRANCH;
   assign isJump    = decodeOut.opcode == `OPCODE_JUMP;
   assign isUpper   = decodeOut.opcode == `OPCODE_UPPER;
   assign known     = isCompute || isLoad || isStore || isBranch || isJump || isUpper ||
                      (decodeOut.opcode == `OPCODE_IMM);
   assign writesRd  = isCompute || isLoad || isJump || isUpper ||
                      (decodeOut.opcode == `OPCODE_IMM);

   assign aluB = isCompute ? opB : decodeOut.imm;

   always_comb begin
      case (decodeOut.funct3)
         `FUNC_ADD: begin
            if (isCompute && decodeOut.funct7 == `AUX_FUNC_ALT) begin
               aluResult = opA - aluB;
            end else begin
               aluResult = opA + aluB;
            end
         end
         `FUNC_SLL:  aluResult = opA << aluB[4:0];
         `FUNC_SLT:  aluResult = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) < $signed(aluB)};
         `FUNC_SLTU: aluResult = {{(`WORD_WIDTH-1){1'b0}}, opA < aluB};
         `FUNC_XOR:  aluResult = opA ^ aluB;
         `FUNC_SR: begin
            if (decodeOut.funct7 == `AUX_FUNC_ALT) begin
               aluResult = $signed(opA) >>> aluB[4:0];
            end else begin
               aluResult = opA >> aluB[4:0];
            end
         end
         `FUNC_OR:   aluResult = opA | aluB;
         default:    aluResult = opA & aluB;
      endcase
   end

   always_comb begin
      case (decodeOut.funct3)
         `FUNC_BEQ:  branchCond = opA == opB;
         `FUNC_BNE:  branchCond = opA != opB;
         `FUNC_BLT:  branchCond = $signed(opA) < $signed(opB);
         `FUNC_BGE:  branchCond = $signed(opA) >= $signed(opB);
         `FUNC_BLTU: branchCond = opA < opB;
         `FUNC_BGEU: branchCond = opA >= opB;
         default:    branchCond = 1'b0;
      endcase
   end

   assign redirect   = decodeOut.valid && (isJump || (isBranch && branchCond));
   assign redirectPc = decodeOut.pc + decodeOut.imm;

   always_comb begin
      if (isUpper) begin
         result = decodeOut.imm;
      end else if (isJump) begin
         result = decodeOut.pc + `WORD_WIDTH'd4;
      end else if (isLoad || isStore) begin
         result = opA + decodeOut.imm;
      end else begin
         result = aluResult;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         execOut <= '0;
      end else if (!halt) begin
         execOut.valid     <= decodeOut.valid;
         execOut.opcode    <= decodeOut.opcode;
         execOut.rd        <= decodeOut.rd;
         execOut.regWrite  <= decodeOut.valid && writesRd && (decodeOut.rd != '0);
         execOut.result    <= result;
         execOut.storeData <= opB;
         execOut.isLoad    <= decodeOut.valid && isLoad;
         execOut.isStore   <= decodeOut.valid && isStore;
         execOut.known     <= known;
      end
   end

endmodule

// ==== memoryStage.sv ====
// Memory access. Drives the data port, picks the write-back value and
// raises the sticky halt when an unknown opcode arrives.
`include "cpuCfg.svh"

module memoryStage import cpuPkg::*; (
   input  logic     clk,
   input  logic     reset,
   input  execOut_t execOut,
   output dataReq_t dataReq,
   input  word_t    dataRdata,
   output logic     halt,
   output wbOut_t   wb
);

   logic live;

   // Nothing issues once halted or for an unknown instruction
   assign live = execOut.valid && execOut.known && !halt;

   // Word accesses only, low address bits dropped
   assign dataReq.addr        = {execOut.result[`WORD_WIDTH-1:2], 2'b00};
   assign dataReq.wdata       = execOut.storeData;
   assign dataReq.writeStrobe = live && execOut.isStore;
   assign dataReq.readStrobe  = live && execOut.isLoad;

   always_ff @(posedge clk) begin
      if (reset) begin
         halt <= 1'b0;
      end else if (execOut.valid && !execOut.known) begin
         halt <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         wb <= '0;
      end else if (!halt) begin
         wb.we <= live && execOut.regWrite;
         wb.rd <= execOut.rd;
         if (execOut.opcode == `OPCODE_LOAD) begin
            wb.value <= dataRdata;
         end else begin
            wb.value <= execOut.result;
         end
      end
   end

endmodule

// ==== pipelinedCpu.sv ====
// Top level of the five-stage core. Chains the stages and exposes the
// instruction-fetch and data ports to the external memories.
`include "cpuCfg.svh"

module pipelinedCpu import cpuPkg::*; (
   input  logic     clk,
   input  logic     reset,
   output word_t    fetchAddr,
   input  word_t    fetchWord,
   output dataReq_t dataReq,
   input  word_t    dataRdata,
   output logic     halt
);

   fetchOut_t  fetchOut;
   decodeOut_t decodeOut;
   execOut_t   execOut;
   wbOut_t     wb;
   logic       redirect;
   word_t      redirectPc;
   logic       stall;
   regIdx_t    execLoadDst;
   logic       execIsLoad;

   // Load sitting in execute, for the hazard check in decode
   assign execLoadDst = decodeOut.rd;
   assign execIsLoad  = decodeOut.valid && (decodeOut.opcode == `OPCODE_LOAD);

   fetchStage fetch (
      .clk        (clk),
      .reset      (reset),
      .halt       (halt),
      .stall      (stall),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .fetchAddr  (fetchAddr),
      .fetchWord  (fetchWord),
      .fetchOut   (fetchOut)
   );

   decodeStage decode (
      .clk         (clk),
      .reset       (reset),
      .halt        (halt),
      .fetchOut    (fetchOut),
      .redirect    (redirect),
      .wb          (wb),
      .execLoadDst (execLoadDst),
      .execIsLoad  (execIsLoad),
      .stall       (stall),
      .decodeOut   (decodeOut)
   );

   executeStage execute (
      .clk        (clk),
      .reset      (reset),
      .halt       (halt),
      .decodeOut  (decodeOut),
      .memFwd     (execOut),
      .wbFwd      (wb),
      .redirect   (redirect),
      .redirectPc (redirectPc),
      .execOut    (execOut)
   );

   memoryStage memory (
      .clk       (clk),
      .reset     (reset),
      .execOut   (execOut),
      .dataReq   (dataReq),
      .dataRdata (dataRdata),
      .halt      (halt),
      .wb        (wb)
   );

endmodule

// ==== cpuTb.sv ====
// Testbench for the pipelined core. Builds a random program, runs it on an
// instruction-set model, plays both memories and checks every DUT store
// against the model's list of stores.
`include "cpuCfg.svh"

module cpuTb import cpuPkg::*; ();

   localparam int progLen     = 80;
   localparam int swStart     = 31 + progLen;
   localparam int haltTimeout = 2000;

   logic     clk;
   logic     reset;
   word_t    fetchAddr;
   word_t    fetchWord;
   dataReq_t dataReq;
   word_t    dataRdata;
   logic     halt;

   word_t  imem [256];
   word_t  dmem [256];
   word_t  modelMem [256];
   word_t  expAddr [$];
   word_t  expData [$];
   word_t  nextAddr;
   word_t  nextData;
   integer seed;
   int     storeCount;
   int     expCount;
   int     cycles;

   pipelinedCpu UUT (
      .clk       (clk),
      .reset     (reset),
      .fetchAddr (fetchAddr),
      .fetchWord (fetchWord),
      .dataReq   (dataReq),
      .dataRdata (dataRdata),
      .halt      (halt)
   );

   // Both memories answer in the same cycle
   assign fetchWord = imem[fetchAddr[9:2]];
   // Without a read strobe the data port returns the inverted word
   assign dataRdata = dataReq.readStrobe ? dmem[dataReq.addr[9:2]] :
                      ~dmem[dataReq.addr[9:2]];

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic abortRun(input string reason);
      $display("%s", reason);
      $display("CHECKS FAILED");
      $fatal(1, "Simulation stopped after a failure");
   endtask

   task automatic check(input string name, input word_t actual, input word_t expected);
      if (actual !== expected) begin
         abortRun($sformatf("Error: %s is %h, expected %h", name, actual, expected));
      end
   endtask

   task automatic checkIdle();
      check("dataReq.writeStrobe", word_t'(dataReq.writeStrobe), 32'd0);
      check("dataReq.readStrobe", word_t'(dataReq.readStrobe), 32'd0);
      check("halt", word_t'(halt), 32'd0);
   endtask

   function automatic int unsigned randomBelow(input int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   function automatic word_t aluResult(logic [2:0] f3, logic alt, word_t a, word_t b);
      word_t r;
      case (f3)
         3'd0:    r = alt ? a - b : a + b;
         3'd1:    r = a << b[4:0];
         3'd2:    r = {31'd0, $signed(a) < $signed(b)};
         3'd3:    r = {31'd0, a < b};
         3'd4:    r = a ^ b;
         3'd5: begin
            if (alt) begin
               r = $signed(a) >>> b[4:0];
            end else begin
               r = a >> b[4:0];
            end
         end
         3'd6:    r = a | b;
         default: r = a & b;
      endcase
      return r;
   endfunction

   function automatic logic branchTaken(logic [2:0] f3, word_t a, word_t b);
      logic t;
      case (f3)
         3'd0:    t = a == b;
         3'd1:    t = a != b;
         3'd4:    t = $signed(a) < $signed(b);
         3'd5:    t = $signed(a) >= $signed(b);
         3'd6:    t = a < b;
         default: t = a >= b;
      endcase
      return t;
   endfunction

   task automatic buildProgram();
      int          i;
      int          kind;
      int          off;
      logic [4:0]  rd;
      logic [4:0]  rs1;
      logic [4:0]  rs2;
      logic [4:0]  shamt;
      logic [2:0]  f3;
      logic [11:0] imm;
      logic [12:0] bImm;
      logic [20:0] jImm;
      word_t       instr;
      for (i = 0; i < 256; i++) begin
         imem[8'(i)] = `NOP_WORD;
      end
      // Give every register a known value first
      for (i = 1; i < 32; i++) begin
         imem[8'(i - 1)] = {12'($random(seed)), 5'd0, `FUNC_ADD, 5'(i), `OPCODE_IMM};
      end
      // Small register pool so that hazards come up often
      for (i = 31; i < swStart; i++) begin
         kind  = int'(randomBelow(10));
         rd    = 5'(randomBelow(8));
         rs1   = 5'(randomBelow(8));
         rs2   = 5'(randomBelow(8));
         shamt = 5'(randomBelow(32));
         f3    = 3'(randomBelow(8));
         imm   = 12'(32'h400 + 4 * randomBelow(256));
         case (kind)
            0, 1: begin
               instr = {((f3 == `FUNC_ADD || f3 == `FUNC_SR) && randomBelow(2) != 0) ?
                        `AUX_FUNC_ALT : `AUX_FUNC_BASE, rs2, rs1, f3, rd, `OPCODE_COMPUTE};
            end
            2, 3: begin
               if (f3 == `FUNC_SLL) begin
                  imm = {`AUX_FUNC_BASE, shamt};
               end else if (f3 == `FUNC_SR) begin
                  imm = {(randomBelow(2) != 0) ? `AUX_FUNC_ALT : `AUX_FUNC_BASE, shamt};
               end else begin
                  imm = 12'($random(seed));
               end
               instr = {imm, rs1, f3, rd, `OPCODE_IMM};
            end
            4:    instr = {20'($random(seed)), rd, `OPCODE_UPPER};
            // LW and SW with funct3 2, base x0
            5, 6: instr = {imm, 5'd0, 3'b010, rd, `OPCODE_LOAD};
            7:    instr = {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], `OPCODE_STORE};
            default: begin
               // Forward targets never pass the final store block
               off = 2 + int'(randomBelow(7));
               if (i + off > swStart) begin
                  off = swStart - i;
               end
               bImm = 13'(off * 4);
               jImm = 21'(off * 4);
               if (kind == 8) begin
                  f3 = 3'(randomBelow(6));
                  if (f3 >= 3'd2) begin
                     f3 = f3 + 3'd2;
                  end
                  instr = {bImm[12], bImm[10:5], rs2, rs1, f3, bImm[4:1], bImm[11],
                           `OPCODE_BRANCH};
               end else begin
                  instr = {jImm[20], jImm[10:1], jImm[11], jImm[19:12], rd, `OPCODE_JUMP};
               end
            end
         endcase
         imem[8'(i)] = instr;
      end
      for (i = 1; i < 32; i++) begin
         imm = 12'(32'h600 + 4 * i);
         imem[8'(swStart + i - 1)] = {imm[11:5], 5'(i), 5'd0, 3'b010, imm[4:0], `OPCODE_STORE};
      end
      imem[8'(swStart + 31)] = 32'h0000007F;
   endtask

   // Sequential reference run, one instruction at a time
   task automatic runModel();
      word_t regs [32];
      word_t pc;
      word_t nextPc;
      word_t w;
      word_t a;
      word_t b;
      word_t immI;
      word_t addr;
      word_t res;
      logic  wr;
      logic  done;
      int    steps;
      for (steps = 0; steps < 32; steps++) begin
         regs[5'(steps)] = '0;
      end
      pc    = '0;
      done  = 1'b0;
      steps = 0;
      while (!done && steps < 1000) begin
         w      = imem[pc[9:2]];
         a      = regs[w[19:15]];
         b      = regs[w[24:20]];
         immI   = {{20{w[31]}}, w[31:20]};
         nextPc = pc + 4;
         res    = '0;
         wr     = 1'b0;
         case (w[6:0])
            `OPCODE_COMPUTE: begin
               res = aluResult(w[14:12], w[30], a, b);
               wr  = 1'b1;
            end
            `OPCODE_IMM: begin
               res = aluResult(w[14:12], w[30] && w[14:12] == `FUNC_SR, a, immI);
               wr  = 1'b1;
            end
            `OPCODE_UPPER: begin
               res = {w[31:12], 12'd0};
               wr  = 1'b1;
            end
            `OPCODE_LOAD: begin
               addr = a + immI;
               res  = modelMem[addr[9:2]];
               wr   = 1'b1;
            end
            `OPCODE_STORE: begin
               addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
               modelMem[addr[9:2]] = b;
               expAddr.push_back({addr[31:2], 2'b00});
               expData.push_back(b);
            end
            `OPCODE_BRANCH: begin
               if (branchTaken(w[14:12], a, b)) begin
                  nextPc = pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
               end
            end
            `OPCODE_JUMP: begin
               res    = pc + 4;
               wr     = 1'b1;
               nextPc = pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            end
            default: done = 1'b1;
         endcase
         if (wr && w[11:7] != 5'd0) begin
            regs[w[11:7]] = res;
         end
         pc = nextPc;
         steps++;
      end
      if (!done) begin
         abortRun("The model never reached the end of the program");
      end
   endtask

   // Store checker, sampled away from the active edge
   always @(negedge clk) begin
      if (reset) begin
         checkIdle();
      end
      if (halt && (dataReq.writeStrobe || dataReq.readStrobe)) begin
         abortRun("A data strobe was active after halt");
      end
      if (!reset && dataReq.writeStrobe) begin
         if (expAddr.size() == 0) begin
            abortRun("The DUT stored more words than the model");
         end else begin
            nextAddr = expAddr.pop_front();
            nextData = expData.pop_front();
            check("dataReq.addr", dataReq.addr, nextAddr);
            check("dataReq.wdata", dataReq.wdata, nextData);
            dmem[dataReq.addr[9:2]] = dataReq.wdata;
            storeCount++;
         end
      end
   end

   initial begin
      int i;
      reset      <= 1'b1;
      seed       = 43175;
      storeCount = 0;
      buildProgram();
      for (i = 0; i < 256; i++) begin
         dmem[8'(i)]     = $random(seed);
         modelMem[8'(i)] = dmem[8'(i)];
      end
      runModel();
      expCount = expAddr.size();
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      // First cycle out of reset
      @(negedge clk);
      checkIdle();
      cycles = 0;
      while (halt !== 1'b1 && cycles < haltTimeout) begin
         @(negedge clk);
         cycles++;
      end
      if (halt !== 1'b1) begin
         abortRun("Timeout: the processor never halted within 2000 cycles");
      end else begin
         // Frozen pipeline must stay quiet
         repeat (10) @(negedge clk);
         if (storeCount != expCount || expAddr.size() != 0) begin
            abortRun($sformatf("Error: storeCount is %h, expected %h", storeCount, expCount));
         end else begin
            $display("ALL CHECKS PASSED");
            $finish;
         end
      end
   end

endmodule

// ==== list.f ====
+incdir+.
cpuPkg.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
pipelinedCpu.sv
cpuTb.sv

// ==== run.sh ====
#!/bin/bash
# Builds the core and its testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -j 0 -f list.f --top-module cpuTb -o cpuSim
./obj_dir/cpuSim | tee sim.log

if grep -qx "ALL CHECKS PASSED" sim.log; then
   echo "Simulation passed"
else
   echo "Simulation failed, see sim.log"
   exit 1
fi
